/* sources.f */
+incdir+common
common/periph_pkg.sv
hw/apb_slot_mux.sv
gpio/apb_gpio.sv
timer/apb_timer.sv
hw/apb_periph_top.sv
tests/tb_clk_gen.sv
tests/apb_periph_asserts.sv
tests/apb_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
( verilator --binary --timing --assert --top-module apb_periph_tb \
	-f sources.f -o apb_periph_sim && ./obj_dir/apb_periph_sim ) > sim.log 2>&1 \
	|| echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0

/* tests/apb_periph_tb.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module apb_periph_tb
	import periph_pkg::*;
;

	localparam int max_rows = 64;
	localparam int timer_period = 20; // (3+1)*(4+1)
	localparam logic [31:0] gpio_base = 32'h4000_0000;
	localparam logic [31:0] tmr_base = 32'h4000_2000;

	logic clk;
	logic rst_i;
	apb_addr_u paddr_i;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	apb_word_t pwdata_i;
	logic pready_o;
	apb_word_t prdata_o;
	logic pslverr_o;
	gpio_vec_t gpio_i;
	gpio_vec_t gpio_o;
	gpio_vec_t gpio_t;
	logic irq_o;

	// stimulus table
	string t_name[max_rows];
	logic t_wr[max_rows];
	logic [31:0] t_addr[max_rows];
	apb_word_t t_wdata[max_rows];
	apb_word_t t_rdata[max_rows];
	logic t_err[max_rows];
	logic t_irq[max_rows];
	gpio_vec_t t_pins[max_rows];
	gpio_vec_t t_exp_o[max_rows];
	gpio_vec_t t_exp_t[max_rows];
	int t_wait[max_rows];
	int n_rows;
	int total_cycles;

	// model state while the table is built
	gpio_vec_t cur_pins;
	gpio_vec_t cur_o;
	gpio_vec_t cur_t;
	logic [31:0] rng_state;

	tb_clk_gen clk_gen_u (.clk_o(clk));

	apb_periph_top uut (
		.clk(clk),
		.rst_i(rst_i),
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.pready_o(pready_o),
		.prdata_o(prdata_o),
		.pslverr_o(pslverr_o),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.gpio_t(gpio_t),
		.irq_o(irq_o)
	);

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic stop_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input apb_word_t exp, input apb_word_t act);
		if (exp !== act)
		begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
		begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_gpio(input string name, input gpio_vec_t exp, input gpio_vec_t act);
		if (exp !== act)
		begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// pin and irq expectations hold before the row's own write lands
	task automatic add_row(input string name, input logic wr, input logic [31:0] addr,
		input apb_word_t wdata, input apb_word_t rdata, input logic err,
		input logic irq, input int wait_cyc);
		t_name[n_rows] = name;
		t_wr[n_rows] = wr;
		t_addr[n_rows] = addr;
		t_wdata[n_rows] = wdata;
		t_rdata[n_rows] = rdata;
		t_err[n_rows] = err;
		t_irq[n_rows] = irq;
		t_pins[n_rows] = cur_pins;
		t_exp_o[n_rows] = cur_o;
		t_exp_t[n_rows] = cur_t;
		t_wait[n_rows] = wait_cyc;
		total_cycles += 2 + wait_cyc;
		n_rows++;
		if (wr && !err && addr == gpio_base)
			cur_o = wdata[`GPIO_WIDTH-1:0];
		if (wr && !err && addr == gpio_base + 32'h4)
			cur_t = wdata[`GPIO_WIDTH-1:0];
	endtask

	task automatic build_table();
		gpio_vec_t r_out;
		gpio_vec_t r_dir;
		gpio_vec_t r_pin;
		r_out = gpio_vec_t'(lcg_next() >> 7);
		r_dir = gpio_vec_t'(lcg_next() >> 11);
		r_pin = gpio_vec_t'(lcg_next() >> 5);
		// reset values
		add_row("reset out", 0, gpio_base, 0, 32'h0, 0, 0, 0);
		add_row("reset dir", 0, gpio_base + 32'h4, 0, 32'h3ff, 0, 0, 0);
		add_row("reset ctrl", 0, tmr_base, 0, 32'h0, 0, 0, 0);
		add_row("reset status", 0, tmr_base + 32'h10, 0, 32'h0, 0, 0, 1);
		// gpio path
		add_row("write out", 1, gpio_base, 32'(r_out), 0, 0, 0, 0);
		add_row("write dir", 1, gpio_base + 32'h4, 32'(r_dir), 0, 0, 0, 0);
		add_row("read out", 0, gpio_base, 0, 32'(r_out), 0, 0, 0);
		add_row("read dir", 0, gpio_base + 32'h4, 0, 32'(r_dir), 0, 0, 0);
		cur_pins = r_pin;
		add_row("drive pins", 0, gpio_base, 0, 32'(r_out), 0, 0, 2);
		add_row("read in", 0, gpio_base + 32'h8, 0, 32'(r_pin), 0, 0, 0);
		// decode errors
		add_row("slot 1", 0, 32'h4000_1000, 0, 0, 1, 0, 0);
		add_row("slot 3", 1, 32'h4000_3000, 32'hffff_ffff, 0, 1, 0, 0);
		add_row("bad window", 1, 32'h5000_0000, 32'h0, 0, 1, 0, 0);
		add_row("gpio offset", 0, gpio_base + 32'hc, 0, 0, 1, 0, 0);
		add_row("write in", 1, gpio_base + 32'h8, 32'h155, 0, 1, 0, 0);
		add_row("write count", 1, tmr_base + 32'hc, 32'h1234, 0, 1, 0, 0);
		add_row("timer offset", 0, tmr_base + 32'h14, 0, 0, 1, 0, 0);
		add_row("out kept", 0, gpio_base, 0, 32'(r_out), 0, 0, 0);
		add_row("dir kept", 0, gpio_base + 32'h4, 0, 32'(r_dir), 0, 0, 0);
		add_row("count kept", 0, tmr_base + 32'hc, 0, 0, 0, 0, 0);
		// timer period, flag due 20 cycles after the enable edge
		add_row("write psc", 1, tmr_base + 32'h4, 32'd3, 0, 0, 0, 0);
		add_row("write reload", 1, tmr_base + 32'h8, 32'd4, 0, 0, 0, 0);
		add_row("read psc", 0, tmr_base + 32'h4, 0, 32'd3, 0, 0, 0);
		add_row("enable", 1, tmr_base, 32'h3, 0, 0, 0, 13);
		add_row("status @14", 0, tmr_base + 32'h10, 0, 0, 0, 0, 0);
		add_row("status @16", 0, tmr_base + 32'h10, 0, 0, 0, 0, 0);
		add_row("status @18", 0, tmr_base + 32'h10, 0, 0, 0, 0, 0);
		add_row("status @20", 0, tmr_base + 32'h10, 0, 32'h1, 0, 1, 0);
		// flag clear, next set lands at +40
		add_row("clear flag", 1, tmr_base + 32'h10, 32'h1, 0, 0, 1, 0);
		add_row("cleared", 0, tmr_base + 32'h10, 0, 0, 0, 0, 12);
		add_row("status @38", 0, tmr_base + 32'h10, 0, 0, 0, 0, 0);
		add_row("status @40", 0, tmr_base + 32'h10, 0, 32'h1, 0, 1, 0);
		// irq_en off restarts the count
		add_row("irq off", 1, tmr_base, 32'h1, 0, 0, 1, 0);
		add_row("clear again", 1, tmr_base + 32'h10, 32'h1, 0, 0, 0, 0);
		add_row("masked clear", 0, tmr_base + 32'h10, 0, 0, 0, 0, 14);
		add_row("masked @19", 0, tmr_base + 32'h10, 0, 0, 0, 0, 0);
		add_row("masked @21", 0, tmr_base + 32'h10, 0, 32'h1, 0, 0, 0);
	endtask

	// one apb transfer, entered and left on a falling edge
	task automatic run_row(input int i);
		paddr_i = t_addr[i];
		pwrite_i = t_wr[i];
		pwdata_i = t_wdata[i];
		gpio_i = t_pins[i];
		psel_i = 1'b1;
		penable_i = 1'b0;
		#1;
		check_bit({t_name[i], " setup pready"}, 1'b0, pready_o);
		@(negedge clk);
		penable_i = 1'b1;
		#1;
		// zero wait state, pready due in the first access cycle
		check_bit({t_name[i], " pready"}, 1'b1, pready_o);
		if (!t_wr[i] || t_err[i])
			check_word(t_name[i], t_rdata[i], prdata_o);
		check_bit({t_name[i], " slverr"}, t_err[i], pslverr_o);
		check_bit({t_name[i], " irq"}, t_irq[i], irq_o);
		check_gpio({t_name[i], " gpio_o"}, t_exp_o[i], gpio_o);
		check_gpio({t_name[i], " gpio_t"}, t_exp_t[i], gpio_t);
		@(negedge clk);
		psel_i = 1'b0;
		penable_i = 1'b0;
		repeat (t_wait[i]) @(negedge clk);
	endtask

	initial
	begin
		rst_i = 1'b1;
		paddr_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		pwdata_i = '0;
		gpio_i = '0;
		n_rows = 0;
		total_cycles = 0;
		cur_pins = '0;
		cur_o = '0;
		cur_t = '1;
		rng_state = 32'h60eb_6e2b;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("All tests passed!");
		$finish;
	end

	// watchdog
	initial
	begin
		int limit;
		#1;
		limit = 2 * (total_cycles + timer_period + 3);
		repeat (limit) @(posedge clk);
		$display("simulation timed out after %0d cycles", limit);
		$display("Test failures found");
		$fatal(1);
	end

endmodule

/* tests/apb_periph_asserts.sv */
`timescale 1ns/1ps

module apb_periph_asserts
(
	input logic clk,
	input logic rst_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [11:0] offset_i,
	input logic wdata_irq_en_i,
	input logic pslverr_o,
	input logic gpio_sel_i,
	input logic tmr_sel_i,
	input logic irq_o
);

	logic irq_en_seen; // ctrl bit1 as written over the bus

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			irq_en_seen <= 1'b0;
		end
		else if (tmr_sel_i & penable_i & pwrite_i & (offset_i == 12'h000))
		begin
			irq_en_seen <= wdata_irq_en_i;
		end
	end

	// access phase needs a setup cycle right before it
	penable_after_setup: assert property (@(posedge clk) disable iff (rst_i)
		$rose(penable_i) |-> $past(psel_i & ~penable_i))
		else $error("penable rose without a setup cycle");

	one_select: assert property (@(posedge clk) disable iff (rst_i)
		!(gpio_sel_i & tmr_sel_i))
		else $error("slot mux asserted more than one select");

	err_in_access: assert property (@(posedge clk) disable iff (rst_i)
		pslverr_o |-> (psel_i & penable_i))
		else $error("pslverr outside an access phase");

	irq_gated: assert property (@(posedge clk) disable iff (rst_i)
		irq_o |-> irq_en_seen)
		else $error("irq_o high with irq_en clear");

endmodule

// top level sees both selects and the timer
bind apb_periph_top apb_periph_asserts asserts_u (
	.clk(clk),
	.rst_i(rst_i),
	.psel_i(psel_i),
	.penable_i(penable_i),
	.pwrite_i(pwrite_i),
	.offset_i(paddr_i.fld.offset),
	.wdata_irq_en_i(pwdata_i[1]),
	.pslverr_o(pslverr_o),
	.gpio_sel_i(gpio_sel),
	.tmr_sel_i(tmr_sel),
	.irq_o(irq_o)
);

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
	output logic clk_o
);

	localparam real half_period = 10.0; // 20 ns clock

	initial
	begin
		clk_o = 1'b0;
	end

	always
	begin
		#(half_period) clk_o = ~clk_o;
	end

endmodule

/* hw/apb_periph_top.sv */
`timescale 1ns/1ps

module apb_periph_top
	import periph_pkg::*;
(
	input  logic clk,
	input  logic rst_i,

	// apb slave port, driven by the bridge
	input  apb_addr_u paddr_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  apb_word_t pwdata_i,
	output logic pready_o,
	output apb_word_t prdata_o,
	output logic pslverr_o,

	// gpio pins, pads live outside
	input  gpio_vec_t gpio_i,
	output gpio_vec_t gpio_o,
	output gpio_vec_t gpio_t, // 1 -> input

	output logic irq_o // timer interrupt
);

	logic gpio_sel;
	logic gpio_ready;
	apb_word_t gpio_rdata;
	logic gpio_slverr;

	logic tmr_sel;
	logic tmr_ready;
	apb_word_t tmr_rdata;
	logic tmr_slverr;

	apb_slot_mux apb_slot_mux_u (
		.paddr_i(paddr_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.gpio_ready_i(gpio_ready),
		.gpio_rdata_i(gpio_rdata),
		.gpio_slverr_i(gpio_slverr),
		.tmr_ready_i(tmr_ready),
		.tmr_rdata_i(tmr_rdata),
		.tmr_slverr_i(tmr_slverr),
		.gpio_sel_o(gpio_sel),
		.tmr_sel_o(tmr_sel),
		.pready_o(pready_o),
		.prdata_o(prdata_o),
		.pslverr_o(pslverr_o)
	);

	// slot 0
	apb_gpio apb_gpio_u (
		.clk(clk),
		.rst_i(rst_i),
		.offset_i(paddr_i.fld.offset),
		.psel_i(gpio_sel),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.pready_o(gpio_ready),
		.prdata_o(gpio_rdata),
		.pslverr_o(gpio_slverr),
		.gpio_o(gpio_o),
		.gpio_t(gpio_t),
		.gpio_i(gpio_i)
	);

	// slot 2
	apb_timer apb_timer_u (
		.clk(clk),
		.rst_i(rst_i),
		.offset_i(paddr_i.fld.offset),
		.psel_i(tmr_sel),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.pwdata_i(pwdata_i),
		.pready_o(tmr_ready),
		.prdata_o(tmr_rdata),
		.pslverr_o(tmr_slverr),
		.irq_o(irq_o)
	);

endmodule

/* timer/apb_timer.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module apb_timer
	import periph_pkg::*;
(
	input  logic clk,
	input  logic rst_i,

	// apb slave, offset view of the address
	input  logic [11:0] offset_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  apb_word_t pwdata_i,
	output logic pready_o,
	output apb_word_t prdata_o,
	output logic pslverr_o,

	output logic irq_o
);

	// register map
	localparam logic [11:0] ofs_ctrl = 12'h000;
	localparam logic [11:0] ofs_psc = 12'h004;
	localparam logic [11:0] ofs_reload = 12'h008;
	localparam logic [11:0] ofs_count = 12'h00c; // read only
	localparam logic [11:0] ofs_status = 12'h010; // w1c

	logic en_r; // ctrl bit0
	logic irq_en_r; // ctrl bit1
	logic flag_r; // sticky status
	logic [`TIMER_WIDTH-1:0] psc_r;
	logic [`TIMER_WIDTH-1:0] reload_r;
	logic [`TIMER_WIDTH-1:0] count_r;
	logic [`TIMER_WIDTH-1:0] psc_cnt;
	apb_word_t rd_val;
	logic acc;
	logic hit;
	logic bad;
	logic wr;
	logic start;
	logic tick;
	logic set_flag;
	logic clr_flag;

	assign acc = psel_i & penable_i;

	always_comb
	begin
		hit = 1'b1;
		rd_val = '0;
		case (offset_i)
			ofs_ctrl: rd_val = {30'd0, irq_en_r, en_r};
			ofs_psc: rd_val = {{(32 - `TIMER_WIDTH){1'b0}}, psc_r};
			ofs_reload: rd_val = {{(32 - `TIMER_WIDTH){1'b0}}, reload_r};
			ofs_count: rd_val = {{(32 - `TIMER_WIDTH){1'b0}}, count_r};
			ofs_status: rd_val = {31'd0, flag_r};
			default: hit = 1'b0;
		endcase
	end

	assign bad = ~hit | (pwrite_i & (offset_i == ofs_count));

	assign pready_o = acc;
	assign pslverr_o = acc & bad;
	assign prdata_o = bad ? '0 : rd_val;

	// legal write, lands on the edge ending the access
	assign wr = acc & pwrite_i & ~bad;

	assign start = wr & (offset_i == ofs_ctrl) & pwdata_i[0];
	assign tick = en_r & (psc_cnt == psc_r); // every psc+1 cycles
	assign set_flag = tick & (count_r == '0);
	assign clr_flag = wr & (offset_i == ofs_status) & pwdata_i[0];

	// config registers
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			en_r <= 1'b0;
			irq_en_r <= 1'b0;
			psc_r <= '0;
			reload_r <= '0;
		end
		else if (wr)
		begin
			case (offset_i)
				ofs_ctrl:
				begin
					en_r <= pwdata_i[0];
					irq_en_r <= pwdata_i[1];
				end
				ofs_psc: psc_r <= pwdata_i[`TIMER_WIDTH-1:0];
				ofs_reload: reload_r <= pwdata_i[`TIMER_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// prescaler and down-counter
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			psc_cnt <= '0;
			count_r <= '0;
		end
		else if (start)
		begin
			psc_cnt <= '0;
			count_r <= reload_r; // restart from reload
		end
		else if (tick)
		begin
			psc_cnt <= '0;
			count_r <= (count_r == '0) ? reload_r : count_r - 1'b1;
		end
		else if (en_r)
		begin
			psc_cnt <= psc_cnt + 1'b1;
		end
	end

	// set beats clear
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			flag_r <= 1'b0;
		end
		else if (set_flag)
		begin
			flag_r <= 1'b1;
		end
		else if (clr_flag)
		begin
			flag_r <= 1'b0;
		end
	end

	assign irq_o = flag_r & irq_en_r; // level, held until cleared

endmodule

/* gpio/apb_gpio.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module apb_gpio
	import periph_pkg::*;
(
	input  logic clk,
	input  logic rst_i,

	// apb slave, offset view of the address
	input  logic [11:0] offset_i,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  apb_word_t pwdata_i,
	output logic pready_o,
	output apb_word_t prdata_o,
	output logic pslverr_o,

	// pin side
	output gpio_vec_t gpio_o,
	output gpio_vec_t gpio_t, // 1 -> input
	input  gpio_vec_t gpio_i
);

	// register map
	localparam logic [11:0] ofs_out = 12'h000;
	localparam logic [11:0] ofs_dir = 12'h004;
	localparam logic [11:0] ofs_in = 12'h008; // read only

	gpio_vec_t out_r;
	gpio_vec_t dir_r;
	gpio_vec_t in_meta;
	gpio_vec_t in_sync;
	gpio_vec_t rd_val;
	logic acc;
	logic hit;
	logic bad;

	assign acc = psel_i & penable_i;

	// read mux
	always_comb
	begin
		hit = 1'b1;
		rd_val = '0;
		case (offset_i)
			ofs_out: rd_val = out_r;
			ofs_dir: rd_val = dir_r;
			ofs_in: rd_val = in_sync;
			default: hit = 1'b0;
		endcase
	end

	// unknown offset or a write to IN
	assign bad = ~hit | (pwrite_i & (offset_i == ofs_in));

	// zero wait state
	assign pready_o = acc;
	assign pslverr_o = acc & bad;
	assign prdata_o = bad ? '0 : {{(32 - `GPIO_WIDTH){1'b0}}, rd_val};

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			out_r <= '0;
			dir_r <= '1; // all pins start as inputs
		end
		else if (acc & pwrite_i)
		begin
			if (offset_i == ofs_out)
			begin
				out_r <= pwdata_i[`GPIO_WIDTH-1:0];
			end
			if (offset_i == ofs_dir)
			begin
				dir_r <= pwdata_i[`GPIO_WIDTH-1:0];
			end
		end
	end

	// two-flop synchronizer on the pins
	always_ff @(posedge clk)
	begin
		in_meta <= gpio_i;
		in_sync <= in_meta;
	end

	assign gpio_o = out_r;
	assign gpio_t = dir_r;

endmodule

/* hw/apb_slot_mux.sv */
`timescale 1ns/1ps
`include "periph_params.svh"

module apb_slot_mux
	import periph_pkg::*;
(
	// master side request
	input  apb_addr_u paddr_i,
	input  logic psel_i,
	input  logic penable_i,

	// gpio results
	input  logic gpio_ready_i,
	input  apb_word_t gpio_rdata_i,
	input  logic gpio_slverr_i,

	// timer results
	input  logic tmr_ready_i,
	input  apb_word_t tmr_rdata_i,
	input  logic tmr_slverr_i,

	// per-slot selects
	output logic gpio_sel_o,
	output logic tmr_sel_o,

	// combined response to the master
	output logic pready_o,
	output apb_word_t prdata_o,
	output logic pslverr_o
);

	logic win_hit;
	logic gpio_hit;
	logic tmr_hit;
	logic acc;

	assign win_hit = (paddr_i.fld.window == `PERIPH_WINDOW);

	// slot 1 (i2c) has nothing fitted, so it falls through as unmapped
	assign gpio_hit = win_hit & (paddr_i.fld.slot == `GPIO_SLOT);
	assign tmr_hit = win_hit & (paddr_i.fld.slot == `TIMER_SLOT);

	assign gpio_sel_o = psel_i & gpio_hit;
	assign tmr_sel_o = psel_i & tmr_hit;

	assign acc = psel_i & penable_i; // access phase

	always_comb
	begin
		if (gpio_sel_o)
		begin
			pready_o = gpio_ready_i;
			prdata_o = gpio_rdata_i;
			pslverr_o = gpio_slverr_i;
		end
		else if (tmr_sel_o)
		begin
			pready_o = tmr_ready_i;
			prdata_o = tmr_rdata_i;
			pslverr_o = tmr_slverr_i;
		end
		else
		begin
			// unmapped, finish at once with an error
			pready_o = acc;
			prdata_o = '0;
			pslverr_o = acc;
		end
	end

endmodule

/* common/periph_pkg.sv */
`include "periph_params.svh"

package periph_pkg;

	// apb data word
	typedef logic [31:0] apb_word_t;

	// one bit per gpio pin
	typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

	// the slot mux reads window/slot, the peripherals read the offset
	typedef union packed {
		logic [31:0] raw; // full bus address
		struct packed {
			logic [15:0] window; // 0x4000 for this block
			logic [3:0] slot; // 4 KB peripheral slot
			logic [11:0] offset; // register offset in the slot
		} fld;
	} apb_addr_u;

endpackage

/* common/periph_params.svh */
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// pin count of the gpio block
`define GPIO_WIDTH 10

// timer counter, prescaler and reload width
`define TIMER_WIDTH 16

// 4 KB slots inside the peripheral window
`define GPIO_SLOT 4'd0
`define TIMER_SLOT 4'd2

// upper half of 0x4000_0000
`define PERIPH_WINDOW 16'h4000

`endif
